// ==== common/qfmt_pkg.sv ====
package qfmt_pkg;

    // ------------------------------------------------------------------------
    // Fixed-point format widths
    // ------------------------------------------------------------------------

    // Fraction bits, shared by Q9.7 and Q0.7
    localparam int q_frac_bits = 7;

    // Signed Q9.7 input word
    localparam int div_in_w = 16;

    // Signed Q0.7 output word
    localparam int div_out_w = 8;

    // Numerator scaled up by the fraction bits
    localparam int div_dvd_w = div_in_w + q_frac_bits;

    // Bit counter must reach div_dvd_w-1
    localparam int div_iter_w = $clog2(div_dvd_w);

    // ------------------------------------------------------------------------
    // Scalar types
    // ------------------------------------------------------------------------
    typedef logic signed [div_in_w-1:0] div_input_qt;
    typedef logic signed [div_out_w-1:0] output_vec_qt;

    // Magnitude only, top value 32767 used as the clamp
    typedef logic [div_in_w-2:0] mag_qt;

endpackage

// ==== common/vec_pkg.sv ====
package vec_pkg;

    import qfmt_pkg::*;

    // ------------------------------------------------------------------------
    // Vector payloads between pipeline stages
    // ------------------------------------------------------------------------

    // Raw Q9.7 input vector at the top
    typedef struct packed {
        div_input_qt x;
        div_input_qt y;
    } vec2_in_t;

    // Norm stage result
    // Signs kept apart from the clamped magnitudes
    typedef struct packed {
        logic  sign_x;
        logic  sign_y;
        mag_qt mag_x;
        mag_qt mag_y;
        mag_qt norm;    // |x| + |y|, saturated
    } vec2_norm_t;

    // Normalized Q0.7 vector at the top
    typedef struct packed {
        output_vec_qt x;
        output_vec_qt y;
    } vec2_out_t;

endpackage

// ==== logic/l1_norm_stage.sv ====
`timescale 1ns/100ps

module l1_norm_stage
    import qfmt_pkg::*, vec_pkg::*;
(
    input  logic       clk,
    input  logic       rst,

    // Upstream handshake
    input  logic       vld_in,
    output logic       rdy_out,
    input  vec2_in_t   vec_in,

    // Downstream handshake
    output logic       vld_out,
    input  logic       rdy_in,
    output vec2_norm_t norm_out
);

    // ------------------------------------------------------------------------
    // Magnitude with clamp
    // ------------------------------------------------------------------------

    // Absolute value of a Q9.7 word
    // -32768 has no 15-bit magnitude, so it clamps to 32767
    function automatic mag_qt clamp_abs(input div_input_qt v);
        logic [div_in_w-1:0] a;
        a = v[div_in_w-1] ? (~v + 1'b1) : v;
        return a[div_in_w-1] ? mag_qt'('1) : a[div_in_w-2:0];
    endfunction

    logic                accept;
    logic                vld_q;
    vec2_norm_t          norm_next;
    vec2_norm_t          norm_q;
    logic [div_in_w-1:0] sum;

    // Register empty or being drained this cycle
    assign rdy_out = !vld_q || rdy_in;
    assign accept  = vld_in && rdy_out;

    // ------------------------------------------------------------------------
    // Split and sum
    // ------------------------------------------------------------------------
    always_comb begin
        norm_next.sign_x = vec_in.x[div_in_w-1];
        norm_next.sign_y = vec_in.y[div_in_w-1];
        norm_next.mag_x  = clamp_abs(vec_in.x);
        norm_next.mag_y  = clamp_abs(vec_in.y);

        // One spare bit catches the carry
        sum = {1'b0, norm_next.mag_x} + {1'b0, norm_next.mag_y};
        // Saturate on carry out of the magnitude field
        norm_next.norm = sum[div_in_w-1] ? mag_qt'('1) : sum[div_in_w-2:0];
    end

    // ------------------------------------------------------------------------
    // Output register
    // ------------------------------------------------------------------------

    // Valid flag, set on accept, cleared once taken
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            vld_q <= 1'b0;
        end else if (accept) begin
            vld_q <= 1'b1;
        end else if (rdy_in) begin
            vld_q <= 1'b0;
        end
    end

    // Payload only moves on accept, held under back-pressure
    always_ff @(posedge clk) begin
        if (accept) begin
            norm_q <= norm_next;
        end
    end

    assign vld_out  = vld_q;
    assign norm_out = norm_q;

endmodule

// ==== int_division/int_division.sv ====
`timescale 1ns/100ps

module int_division
    import qfmt_pkg::*;
(
    input  logic         clk,
    input  logic         rst,

    // Handshake
    input  logic         vld_in,
    input  logic         rdy_in,
    output logic         vld_out,
    output logic         rdy_out,

    // Operands as sign plus magnitude
    input  logic         sign_in,
    input  mag_qt        numerator_in,
    input  mag_qt        denominator_in,
    output output_vec_qt quotient_out
);

    // ------------------------------------------------------------------------
    // Declarations
    // ------------------------------------------------------------------------

    typedef enum logic [1:0] {
        DIV_IDLE,
        DIV_RUN,
        DIV_DONE
    } div_state_e;

    div_state_e state;

    // Control
    logic busy;
    logic valid_reg;
    logic accept;
    logic take;

    // Latched operands
    logic  sign_reg;
    mag_qt num_reg;
    mag_qt den_reg;
    logic  den_zero;

    // Working registers
    // Remainder needs one bit over the divisor plus a sign
    logic signed [div_in_w:0]   rem;
    logic signed [div_in_w:0]   rem_next;
    logic [div_dvd_w-1:0]       divd;
    logic [div_dvd_w-1:0]       q_reg;
    logic [div_iter_w-1:0]      bit_idx;

    // Result magnitude, 7 bits of Q0.7
    logic [div_out_w-2:0] abs_quotient;

    // ------------------------------------------------------------------------
    // Handshake
    // ------------------------------------------------------------------------

    // One item at a time, free again once the result is taken
    assign rdy_out = !busy;
    assign vld_out = valid_reg;
    assign accept  = vld_in && rdy_out;
    assign take    = valid_reg && rdy_in;

    assign den_zero = (den_reg == '0);

    // ------------------------------------------------------------------------
    // Input latch
    // ------------------------------------------------------------------------
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy <= 1'b0;
        end else if (accept) begin
            busy <= 1'b1;
        end else if (take) begin
            busy <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            sign_reg <= sign_in;
            num_reg  <= numerator_in;
            den_reg  <= denominator_in;
        end
    end

    // ------------------------------------------------------------------------
    // Non-restoring step
    // ------------------------------------------------------------------------
    always_comb begin
        // Shift in the next dividend bit, MSB first
        rem_next    = rem <<< 1;
        rem_next[0] = divd[bit_idx];
        // Subtract after a positive remainder, add after a negative one
        if (rem >= 0) begin
            rem_next = rem_next - $signed({2'b00, den_reg});
        end else begin
            rem_next = rem_next + $signed({2'b00, den_reg});
        end
    end

    // ------------------------------------------------------------------------
    // Divider FSM
    // ------------------------------------------------------------------------
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= DIV_IDLE;
            valid_reg <= 1'b0;
            bit_idx   <= '0;
        end else begin
            if (take) begin
                valid_reg <= 1'b0;
            end

            case (state)
                // Wait for a latched item with no result pending
                DIV_IDLE: begin
                    if (busy && !valid_reg) begin
                        // Zero denominator skips the iterations
                        if (den_zero) begin
                            state <= DIV_DONE;
                        end else begin
                            bit_idx <= div_iter_w'(div_dvd_w - 1);
                            state   <= DIV_RUN;
                        end
                    end
                end

                // One quotient bit per cycle
                DIV_RUN: begin
                    if (bit_idx == '0) begin
                        state <= DIV_DONE;
                    end else begin
                        bit_idx <= bit_idx - 1'b1;
                    end
                end

                // Publish
                DIV_DONE: begin
                    valid_reg <= 1'b1;
                    state     <= DIV_IDLE;
                end

                default: begin
                    state <= DIV_IDLE;
                end
            endcase
        end
    end

    // Datapath registers follow the FSM state
    always_ff @(posedge clk) begin
        case (state)
            DIV_IDLE: begin
                // Scale numerator by 2^7 for the Q0.7 result
                divd  <= div_dvd_w'(num_reg) << q_frac_bits;
                rem   <= '0;
                q_reg <= '0;
            end

            DIV_RUN: begin
                rem            <= rem_next;
                q_reg[bit_idx] <= (rem_next >= 0);
            end

            DIV_DONE: begin
                // Zero for x/0, 127 for anything at or above 1.0
                if (den_zero) begin
                    abs_quotient <= '0;
                end else if (|q_reg[div_dvd_w-1:div_out_w-1]) begin
                    abs_quotient <= '1;
                end else begin
                    abs_quotient <= q_reg[div_out_w-2:0];
                end
            end

            default: begin
                rem <= rem;
            end
        endcase
    end

    // ------------------------------------------------------------------------
    // Signed result
    // ------------------------------------------------------------------------

    // Magnitude capped at 127, so negation always fits
    assign quotient_out = sign_reg ? output_vec_qt'(-{1'b0, abs_quotient})
                                   : output_vec_qt'({1'b0, abs_quotient});

endmodule

// ==== logic/vec_normalizer.sv ====
`timescale 1ns/100ps

module vec_normalizer
    import qfmt_pkg::*, vec_pkg::*;
(
    input  logic      clk,
    input  logic      rst,

    // Upstream handshake
    input  logic      vld_in,
    output logic      rdy_out,
    input  vec2_in_t  vec_in,

    // Downstream handshake
    output logic      vld_out,
    input  logic      rdy_in,
    output vec2_out_t vec_out
);

    // Norm stage to divider pair
    logic       norm_vld;
    logic       norm_rdy;
    vec2_norm_t norm;

    // Divider pair
    logic         div_vld_in;
    logic         div_rdy_in;
    logic         div_x_rdy;
    logic         div_y_rdy;
    logic         div_x_vld;
    logic         div_y_vld;
    output_vec_qt quot_x;
    output_vec_qt quot_y;

    // ------------------------------------------------------------------------
    // Norm stage
    // ------------------------------------------------------------------------
    l1_norm_stage norm_i (
        .clk      (clk),
        .rst      (rst),
        .vld_in   (vld_in),
        .rdy_out  (rdy_out),
        .vec_in   (vec_in),
        .vld_out  (norm_vld),
        .rdy_in   (norm_rdy),
        .norm_out (norm)
    );

    // ------------------------------------------------------------------------
    // Fork
    // ------------------------------------------------------------------------

    // Issue only when both dividers can take it, so they run in lockstep
    assign norm_rdy   = div_x_rdy && div_y_rdy;
    assign div_vld_in = norm_vld && norm_rdy;

    int_division div_x (
        .clk            (clk),
        .rst            (rst),
        .vld_in         (div_vld_in),
        .rdy_in         (div_rdy_in),
        .vld_out        (div_x_vld),
        .rdy_out        (div_x_rdy),
        .sign_in        (norm.sign_x),
        .numerator_in   (norm.mag_x),
        .denominator_in (norm.norm),
        .quotient_out   (quot_x)
    );

    int_division div_y (
        .clk            (clk),
        .rst            (rst),
        .vld_in         (div_vld_in),
        .rdy_in         (div_rdy_in),
        .vld_out        (div_y_vld),
        .rdy_out        (div_y_rdy),
        .sign_in        (norm.sign_y),
        .numerator_in   (norm.mag_y),
        .denominator_in (norm.norm),
        .quotient_out   (quot_y)
    );

    // ------------------------------------------------------------------------
    // Join
    // ------------------------------------------------------------------------

    // Both results leave together
    assign vld_out    = div_x_vld && div_y_vld;
    assign div_rdy_in = rdy_in && vld_out;

    assign vec_out.x = quot_x;
    assign vec_out.y = quot_y;

endmodule

// ==== test/vec_normalizer_props.sv ====
`timescale 1ns/100ps

module vec_normalizer_props
    import vec_pkg::*;
(
    input logic      clk,
    input logic      rst,
    input logic      vld_out,
    input logic      rdy_in,
    input vec2_out_t vec_out,
    input logic      div_x_vld,
    input logic      div_y_vld
);

    // Number of assertion failures so far
    int unsigned fail_count = 0;

    // ------------------------------------------------------------------------
    // Output handshake
    // ------------------------------------------------------------------------

    // A stalled result keeps its valid and its data
    hold_out: assert property (@(posedge clk) disable iff (rst)
        vld_out && !rdy_in |=> vld_out && $stable(vec_out))
    else begin
        $error("vld_out or vec_out changed while rdy_in was low");
        fail_count++;
    end

    // Divider pair runs in lockstep
    lockstep: assert property (@(posedge clk) disable iff (rst) div_x_vld == div_y_vld)
    else begin
        $error("div_x and div_y valids differ");
        fail_count++;
    end

    // Nothing valid right after reset
    reset_idle: assert property (@(posedge clk) $fell(rst) |-> !vld_out)
    else begin
        $error("vld_out high in the first cycle after reset");
        fail_count++;
    end

endmodule

bind vec_normalizer vec_normalizer_props props_i (
    .clk       (clk),
    .rst       (rst),
    .vld_out   (vld_out),
    .rdy_in    (rdy_in),
    .vec_out   (vec_out),
    .div_x_vld (div_x_vld),
    .div_y_vld (div_y_vld)
);

// ==== test/vec_normalizer_tb.sv ====
`timescale 1ns/100ps

module vec_normalizer_tb
    import qfmt_pkg::*, vec_pkg::*;
();

    localparam int clk_period = 40;
    // Vectors sent by all tests together
    localparam int num_vectors = 4 + 2 + 3 + 200 + 16;
    // Divider latency per vector plus slack for stalls
    localparam int timeout_cycles = num_vectors * (div_dvd_w + 8) + 2000;

    logic      clk;
    logic      rst;
    logic      vld_in;
    logic      rdy_out;
    vec2_in_t  vec_in;
    logic      vld_out;
    logic      rdy_in;
    vec2_out_t vec_out;

    vec2_out_t   exp_q[$];
    logic [31:0] lfsr_state = 32'he7f5b816;

    vec_normalizer vec_normalizer_i (.*);

    always #(clk_period / 2) clk = ~clk;

    // ------------------------------------------------------------------------
    // Failure handling and checks
    // ------------------------------------------------------------------------
    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Test failed");
        $fatal(1, "run stopped");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp));
        end
    endtask

    // ------------------------------------------------------------------------
    // Reference model
    // ------------------------------------------------------------------------

    // |c| clamped to the 15-bit magnitude range
    function automatic int abs_clamped(input int c);
        int m;
        m = (c < 0) ? -c : c;
        return (m > 32767) ? 32767 : m;
    endfunction

    // floor(mag * 128 / norm) capped at 127 and given the component's sign
    function automatic output_vec_qt scale_comp(input int c, input int mag, input int norm);
        int q;
        if (norm == 0) begin
            return '0;
        end
        q = mag * 128 / norm;
        if (q > 127) begin
            q = 127;
        end
        return (c < 0) ? output_vec_qt'(-q) : output_vec_qt'(q);
    endfunction

    function automatic vec2_out_t expected_out(input vec2_in_t v);
        int        mx;
        int        my;
        int        norm;
        vec2_out_t r;
        mx   = abs_clamped(v.x);
        my   = abs_clamped(v.y);
        norm = (mx + my > 32767) ? 32767 : mx + my;
        r.x  = scale_comp(v.x, mx, norm);
        r.y  = scale_comp(v.y, my, norm);
        return r;
    endfunction

    // ------------------------------------------------------------------------
    // Random source
    // ------------------------------------------------------------------------
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    // One LFSR step per bit
    task automatic take_bits(input int n, output logic [31:0] bits);
        bits = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            bits       = {bits[30:0], lfsr_state[0]};
        end
    endtask

    task automatic random_vec(output vec2_in_t v);
        logic [31:0] bits;
        take_bits(16, bits);
        v.x = bits[15:0];
        take_bits(16, bits);
        v.y = bits[15:0];
    endtask

    // ------------------------------------------------------------------------
    // Drivers and collector
    // ------------------------------------------------------------------------

    // Hold the vector until the DUT takes it
    // Valid stays up for the next call
    task automatic send_vec(input vec2_in_t v);
        @(negedge clk);
        vld_in = 1'b1;
        vec_in = v;
        @(posedge clk);
        while (!rdy_out) begin
            @(posedge clk);
        end
        exp_q.push_back(expected_out(v));
    endtask

    task automatic send_xy(input int x, input int y);
        vec2_in_t v;
        v.x = div_input_qt'(x);
        v.y = div_input_qt'(y);
        send_vec(v);
    endtask

    task automatic end_input();
        @(negedge clk);
        vld_in = 1'b0;
    endtask

    // Stop offering and wait for every pending result
    task automatic drain();
        end_input();
        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
    endtask

    // Compare every output transfer in order
    always @(posedge clk) begin : collect
        vec2_out_t exp_v;
        if (!rst && vld_out && rdy_in) begin
            if (exp_q.size() == 0) begin
                abort_run("Output transfer with no vector pending");
            end else begin
                exp_v = exp_q.pop_front();
                check_value("vec_out.x", {24'h0, vec_out.x}, {24'h0, exp_v.x});
                check_value("vec_out.y", {24'h0, vec_out.y}, {24'h0, exp_v.y});
            end
        end
    end

    always @(negedge clk) begin
        if (vec_normalizer_i.props_i.fail_count != 0) begin
            abort_run("A property assertion failed");
        end
    end

    // Watchdog
    initial begin
        repeat (timeout_cycles) @(posedge clk);
        abort_run("Timeout, the run did not finish in time");
    end

    // ------------------------------------------------------------------------
    // Directed tests
    // ------------------------------------------------------------------------
    task automatic reset_state_test();
        @(negedge clk);
        check_value("vld_out", vld_out, 0);
        check_value("rdy_out", rdy_out, 1);
    endtask

    // Q9.7 raw values where 128 is 1.0
    task automatic axis_sign_test();
        send_xy(128, 0);
        send_xy(0, -448);
        send_xy(-256, 256);
        send_xy(640, -128);
        drain();
    endtask

    task automatic zero_vector_test();
        send_xy(0, 0);
        send_xy(384, -896);
        drain();
    endtask

    // -32768 clamps and the large pair saturates the norm
    task automatic extreme_value_test();
        send_xy(-32768, 100);
        send_xy(-32768, -32768);
        send_xy(32767, 32767);
        drain();
    endtask

    task automatic random_stream_test();
        vec2_in_t v;
        for (int i = 0; i < 200; i++) begin
            random_vec(v);
            send_vec(v);
        end
        drain();
    endtask

    task automatic backpressure_test();
        vec2_in_t    v;
        logic [31:0] r;
        bit          sent_all;
        sent_all = 1'b0;
        @(negedge clk);
        rdy_in = 1'b0;
        fork
            begin
                for (int i = 0; i < 16; i++) begin
                    random_vec(v);
                    send_vec(v);
                end
                end_input();
                sent_all = 1'b1;
            end
            begin
                // Pipeline fills up and the input stalls
                repeat (100) @(negedge clk);
                check_value("rdy_out", rdy_out, 0);
                check_value("vld_out", vld_out, 1);
                while (!sent_all || exp_q.size() != 0) begin
                    @(negedge clk);
                    take_bits(1, r);
                    rdy_in = r[0];
                end
            end
        join
        @(negedge clk);
        rdy_in = 1'b1;
    endtask

    initial begin
        clk    = 1'b0;
        rst    = 1'b1;
        vld_in = 1'b0;
        rdy_in = 1'b1;
        vec_in = '0;
        repeat (2) @(negedge clk);
        rst = 1'b0;

        reset_state_test();
        axis_sign_test();
        zero_vector_test();
        extreme_value_test();
        random_stream_test();
        backpressure_test();

        // Assertion failures from the last cycles are not yet seen by the poller
        if (vec_normalizer_i.props_i.fail_count != 0) begin
            abort_run("A property assertion failed");
        end else begin
            $display("Test passed");
            $finish;
        end
    end

endmodule

// ==== src.f ====
common/qfmt_pkg.sv
common/vec_pkg.sv
logic/l1_norm_stage.sv
int_division/int_division.sv
logic/vec_normalizer.sv
test/vec_normalizer_props.sv
test/vec_normalizer_tb.sv
